// File: compile.f
+incdir+rtl
rtl/mrg_pkg.sv
rtl/mrg_if.sv
rtl/kernel_control.sv
rtl/request_engine.sv
rtl/request_arbiter.sv
rtl/request_fifo.sv
rtl/memory_request_front_end.sv
test/front_end_assert.sv
test/tb_memory_request_front_end.sv

// File: Makefile
# Verilator simulation of the memory request front end

VERILATOR ?= verilator
TOP       ?= tb_memory_request_front_end
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# Build, run, then decide from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG) || ! grep -q "TESTS PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/tb_memory_request_front_end.sv
// Front end testbench
`timescale 1ns/1ps
`include "mrg_cfg.svh"

module tb_memory_request_front_end;
  import mrg_pkg::*;

  localparam int NUM_ENGINES = `MRG_NUM_ENGINES;
  localparam int MAX_COUNT   = 1 << `MRG_COUNT_W;
  localparam int NUM_ROWS    = 6;

  // One run with descriptor, stall rate and optional second start
  typedef struct packed {
    addr_t  base;
    count_t count;
    int     stall_pct;
    logic   extra_start;
  } run_row_t;

  // --------------------
  // Run table
  // --------------------
  run_row_t rows [NUM_ROWS] = '{
    '{32'h1000_0000, 8'd3, 0,  1'b0},   // plain run without stalls
    '{32'h2000_0000, 8'd5, 70, 1'b0},   // heavy back-pressure
    '{32'h3000_0000, 8'd0, 0,  1'b0},   // empty run
    '{32'h0004_0000, 8'd6, 30, 1'b1},   // start again mid-run
    '{32'h7fff_f000, 8'd8, 70, 1'b0},   // deeper than the FIFO
    '{32'h0000_0040, 8'd2, 0,  1'b0}    // new base right after
  };

  logic   ap_clk;
  logic   control_areset;
  logic   ap_start;
  addr_t  descriptor_base;
  count_t descriptor_count;
  logic   mem_ready;
  logic   ap_idle;
  logic   ap_ready;
  logic   ap_done;
  logic   setup_busy;
  logic   mem_valid;
  addr_t  mem_addr;
  engine_id_t mem_engine;

  // Reference model of expected addresses per engine
  addr_t exp_addr [NUM_ENGINES][MAX_COUNT];
  int    exp_idx [NUM_ENGINES];
  int    exp_len [NUM_ENGINES];
  int    stall_pct;
  int    ready_count;
  int    popped;
  int    mismatch_count;
  int    other_errors;

  memory_request_front_end i_dut (
    .ap_clk          (ap_clk),
    .control_areset  (control_areset),
    .ap_start        (ap_start),
    .descriptor_base (descriptor_base),
    .descriptor_count(descriptor_count),
    .mem_ready       (mem_ready),
    .ap_idle         (ap_idle),
    .ap_ready        (ap_ready),
    .ap_done         (ap_done),
    .setup_busy      (setup_busy),
    .mem_valid       (mem_valid),
    .mem_addr        (mem_addr),
    .mem_engine      (mem_engine)
  );

  bind memory_request_front_end front_end_assert i_front_end_assert (
    .ap_clk(ap_clk), .control_areset(control_areset), .ap_done(ap_done),
    .ap_ready(ap_ready), .mem_valid(mem_valid), .mem_ready(mem_ready),
    .mem_addr(mem_addr)
  );

  initial begin
    ap_clk = 1'b0;
    forever #5 ap_clk = ~ap_clk;
  end

  // Random memory stalls at the row's rate
  always @(posedge ap_clk) begin
    mem_ready <= (int'($urandom_range(99)) >= stall_pct);
  end

  // --------------------
  // Checkers
  // --------------------
  task automatic check_level(input string name, input logic expected, input logic actual);
    assert (actual === expected) else begin
      mismatch_count++;
      $display("mismatch at %0t: %s expected %0b actual %0b", $time, name, expected, actual);
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    assert (actual == expected) else begin
      mismatch_count++;
      $display("mismatch at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
    end
  endtask

  // Next expected address of the tagged engine
  task automatic check_pop();
    int e;
    e = int'(mem_engine);
    popped++;
    assert (e < NUM_ENGINES && exp_idx[e] < exp_len[e]) else begin
      other_errors++;
      $display("error at %0t: unexpected extra request from engine %0d", $time, e);
    end
    if (e < NUM_ENGINES && exp_idx[e] < exp_len[e]) begin
      assert (mem_addr === exp_addr[e][exp_idx[e]]) else begin
        mismatch_count++;
        $display("mismatch at %0t: mem_addr (engine %0d) expected %h actual %h",
                 $time, e, exp_addr[e][exp_idx[e]], mem_addr);
      end
      exp_idx[e]++;
    end
  endtask

  // Monitor on the falling edge away from the drive edge
  always @(negedge ap_clk) begin
    if (!control_areset) begin
      if (ap_ready) begin
        ready_count++;
      end
      if (mem_valid && mem_ready) begin
        check_pop();
      end
    end
  end

  // Engine e covers words e*count .. e*count+count-1 past base
  task automatic load_model(input addr_t base, input count_t count);
    int e;
    int k;
    for (e = 0; e < NUM_ENGINES; e++) begin
      exp_len[e] = int'(count);
      exp_idx[e] = 0;
      for (k = 0; k < int'(count); k++) begin
        exp_addr[e][k] = base + addr_t'((e * int'(count) + k) * `MRG_WORD_BYTES);
      end
    end
  endtask

  task automatic check_after_reset();
    int cycles;
    cycles = 0;
    @(negedge ap_clk);
    check_level("ap_idle", 1'b1, ap_idle);
    check_level("ap_done", 1'b0, ap_done);
    check_level("ap_ready", 1'b0, ap_ready);
    check_level("mem_valid", 1'b0, mem_valid);
    while (setup_busy && cycles < `MRG_RESET_BUSY_CYCLES + 2) begin
      @(negedge ap_clk);
      cycles++;
    end
    assert (!setup_busy) else begin
      other_errors++;
      $display("error at %0t: setup_busy still high %0d cycles after reset", $time, cycles);
    end
  endtask

  // --------------------
  // One table row
  // --------------------
  task automatic run_row(input run_row_t row);
    int e;
    @(posedge ap_clk);
    load_model(row.base, row.count);
    stall_pct   <= row.stall_pct;
    ready_count = 0;
    popped      = 0;
    descriptor_base  <= row.base;
    descriptor_count <= row.count;
    ap_start         <= 1'b1;
    @(posedge ap_clk);
    ap_start <= 1'b0;
    do @(negedge ap_clk); while (!ap_ready);
    // Idle drops with acceptance
    check_level("ap_idle", 1'b0, ap_idle);
    if (row.extra_start) begin
      // Different descriptor that must not be taken
      @(posedge ap_clk);
      ap_start         <= 1'b1;
      descriptor_base  <= ~row.base;
      descriptor_count <= row.count + count_t'(1);
      @(posedge ap_clk);
      ap_start <= 1'b0;
    end
    do @(negedge ap_clk); while (!ap_done);
    check_level("ap_idle", 1'b1, ap_idle);
    check_level("mem_valid", 1'b0, mem_valid);
    // Quiet cycles catch late requests or a second run
    repeat (4) @(negedge ap_clk);
    check_level("ap_idle", 1'b1, ap_idle);
    check_count("ap_ready pulses", 1, ready_count);
    check_count("request total", NUM_ENGINES * int'(row.count), popped);
    for (e = 0; e < NUM_ENGINES; e++) begin
      check_count($sformatf("requests of engine %0d", e), exp_len[e], exp_idx[e]);
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    void'($urandom(48));
    mismatch_count   = 0;
    other_errors     = 0;
    ready_count      = 0;
    popped           = 0;
    stall_pct        = 0;
    control_areset   = 1'b1;
    ap_start         = 1'b0;
    descriptor_base  = '0;
    descriptor_count = '0;
    mem_ready        = 1'b1;
    repeat (4) @(posedge ap_clk);
    control_areset <= 1'b0;
    check_after_reset();
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(rows[r]);
    end
    $display("summary: %0d mismatches, %0d other errors", mismatch_count, other_errors);
    if (mismatch_count == 0 && other_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Budget of 20 cycles per request plus slack per row
  initial begin
    int limit;
    limit = 200;
    for (int r = 0; r < NUM_ROWS; r++) begin
      limit += NUM_ENGINES * int'(rows[r].count) * 20 + 20;
    end
    repeat (limit) @(posedge ap_clk);
    $display("error: watchdog expired after %0d cycles, run did not finish", limit);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: test/front_end_assert.sv
// Front end protocol assertions
`timescale 1ns/1ps

module front_end_assert (
  input logic           ap_clk,
  input logic           control_areset,
  input logic           ap_done,
  input logic           ap_ready,
  input logic           mem_valid,
  input logic           mem_ready,
  input mrg_pkg::addr_t mem_addr
);

  // --------------------
  // Control pulses
  // --------------------
  a_done_pulse: assert property (@(posedge ap_clk) disable iff (control_areset)
    ap_done |=> !ap_done)
    else $error("ap_done high for two consecutive cycles");

  a_ready_pulse: assert property (@(posedge ap_clk) disable iff (control_areset)
    ap_ready |=> !ap_ready)
    else $error("ap_ready high for two consecutive cycles");

  // --------------------
  // Memory side
  // --------------------
  // Head held under back-pressure
  a_addr_stable: assert property (@(posedge ap_clk) disable iff (control_areset)
    (mem_valid && !mem_ready) |=> $stable(mem_addr))
    else $error("mem_addr changed while stalled");

  // Done only once the FIFO has drained
  a_done_empty: assert property (@(posedge ap_clk) disable iff (control_areset)
    !(ap_done && mem_valid))
    else $error("ap_done raised with a request still pending");

endmodule

// File: rtl/memory_request_front_end.sv
// Memory request front end top
`timescale 1ns/1ps
`include "mrg_cfg.svh"

module memory_request_front_end (
  input  logic                ap_clk,
  input  logic                control_areset,
  input  logic                ap_start,
  input  mrg_pkg::addr_t      descriptor_base,
  input  mrg_pkg::count_t     descriptor_count,
  input  logic                mem_ready,
  output logic                ap_idle,
  output logic                ap_ready,
  output logic                ap_done,
  output logic                setup_busy,
  output logic                mem_valid,
  output mrg_pkg::addr_t      mem_addr,
  output mrg_pkg::engine_id_t mem_engine
);
  import mrg_pkg::*;

  localparam int NUM_ENGINES = `MRG_NUM_ENGINES;

  descriptor_t  descriptor_in;
  mem_request_t arb_data;
  mem_request_t fifo_head;
  logic         arb_push;
  logic         fifo_full;
  logic         fifo_empty;
  logic         fifo_reset_busy;

  descriptor_if #(.NUM_ENGINES(NUM_ENGINES)) desc_if ();
  engine_request_if req_if [NUM_ENGINES] ();

  // Host descriptor packing
  assign descriptor_in = '{base: descriptor_base, count: descriptor_count};

  // --------------------
  // Control
  // --------------------
  kernel_control inst_kernel_control (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .ap_start       (ap_start),
    .descriptor_in  (descriptor_in),
    .fifo_reset_busy(fifo_reset_busy),
    .fifo_empty     (fifo_empty),
    .desc           (desc_if),
    .ap_idle        (ap_idle),
    .ap_ready       (ap_ready),
    .ap_done        (ap_done),
    .setup_busy     (setup_busy)
  );

  // --------------------
  // Engines
  // --------------------
  for (genvar e = 0; e < NUM_ENGINES; e++) begin : g_engine
    request_engine #(
      .ENGINE_ID(e)
    ) inst_request_engine (
      .ap_clk        (ap_clk),
      .control_areset(control_areset),
      .desc          (desc_if),
      .req_port      (req_if[e])
    );
  end

  request_arbiter #(
    .payload_t(mem_request_t),
    .NUM_PORTS(NUM_ENGINES)
  ) inst_request_arbiter (
    .ap_clk        (ap_clk),
    .control_areset(control_areset),
    .ports         (req_if),
    .fifo_full     (fifo_full),
    .push          (arb_push),
    .push_data     (arb_data)
  );

  // Pop gated by valid inside the FIFO
  request_fifo #(
    .payload_t(mem_request_t),
    .DEPTH    (`MRG_FIFO_DEPTH)
  ) inst_request_fifo (
    .ap_clk        (ap_clk),
    .control_areset(control_areset),
    .push          (arb_push),
    .push_data     (arb_data),
    .pop           (mem_ready),
    .head          (fifo_head),
    .valid         (mem_valid),
    .full          (fifo_full),
    .empty         (fifo_empty),
    .reset_busy    (fifo_reset_busy)
  );

  // FIFO head fields
  assign mem_addr   = fifo_head.addr;
  assign mem_engine = fifo_head.engine;

endmodule

// File: rtl/request_fifo.sv
// Request FIFO with reset-busy window
`timescale 1ns/1ps
`include "mrg_cfg.svh"

module request_fifo #(
  parameter type payload_t = mrg_pkg::mem_request_t,
  parameter int  DEPTH     = `MRG_FIFO_DEPTH
) (
  input  logic     ap_clk,
  input  logic     control_areset,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     valid,
  output logic     full,
  output logic     empty,
  output logic     reset_busy
);
  import mrg_pkg::*;

  localparam int PTR_W  = idx_width(DEPTH);
  localparam int CNT_W  = idx_width(DEPTH + 1);
  localparam int BUSY_W = idx_width(`MRG_RESET_BUSY_CYCLES + 1);

  payload_t          mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [BUSY_W-1:0] busy_cnt;
  logic              wr_en;
  logic              rd_en;

  // Pointer step with wrap at DEPTH
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  // --------------------
  // Reset-busy window
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      busy_cnt <= BUSY_W'(`MRG_RESET_BUSY_CYCLES);
    end else if (busy_cnt != '0) begin
      busy_cnt <= busy_cnt - BUSY_W'(1);
    end
  end

  assign reset_busy = (busy_cnt != '0);

  // Looks full while busy so writers hold off
  assign full  = (count == CNT_W'(DEPTH)) || reset_busy;
  assign empty = (count == '0);
  assign valid = !empty;
  assign head  = mem[rd_ptr];

  assign wr_en = push && !full;
  assign rd_en = pop && valid;

  // --------------------
  // Storage and pointers
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Occupancy, unchanged on simultaneous push and pop
      case ({wr_en, rd_en})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

// File: rtl/request_arbiter.sv
// Round-robin request arbiter
`timescale 1ns/1ps
`include "mrg_cfg.svh"

module request_arbiter #(
  parameter type payload_t = mrg_pkg::mem_request_t,
  parameter int  NUM_PORTS = `MRG_NUM_ENGINES
) (
  input  logic              ap_clk,
  input  logic              control_areset,
  engine_request_if.arbiter ports [NUM_PORTS],
  input  logic              fifo_full,
  output logic              push,
  output payload_t          push_data
);
  import mrg_pkg::*;

  localparam int IDX_W = idx_width(NUM_PORTS);

  logic [NUM_PORTS-1:0] req_vec;
  payload_t             payload_arr [NUM_PORTS];
  logic [IDX_W-1:0]     last_q;
  logic [IDX_W-1:0]     sel;
  logic                 found;

  // --------------------
  // Port flattening
  // --------------------
  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
    assign req_vec[i]     = ports[i].req;
    assign payload_arr[i] = ports[i].payload;
    // Grant only with a real push
    assign ports[i].grant = push && (sel == IDX_W'(i));
  end

  // Search starts one past the last winner
  always_comb begin
    int idx;
    found = 1'b0;
    sel   = last_q;
    for (int k = 1; k <= NUM_PORTS; k++) begin
      idx = (int'(last_q) + k) % NUM_PORTS;
      if (!found && req_vec[idx]) begin
        found = 1'b1;
        sel   = IDX_W'(idx);
      end
    end
  end

  // Full FIFO blocks every grant
  assign push      = found && !fifo_full;
  assign push_data = payload_arr[sel];

  // Round-robin pointer, port 0 first after reset
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      last_q <= IDX_W'(NUM_PORTS - 1);
    end else if (push) begin
      last_q <= sel;
    end
  end

endmodule

// File: rtl/request_engine.sv
// Read request engine
`timescale 1ns/1ps
`include "mrg_cfg.svh"

module request_engine #(
  parameter int ENGINE_ID = 0
) (
  input  logic             ap_clk,
  input  logic             control_areset,
  descriptor_if.engine     desc,
  engine_request_if.engine req_port
);
  import mrg_pkg::*;

  localparam addr_t WORD_STEP = addr_t'(`MRG_WORD_BYTES);

  logic   busy_q;
  count_t remaining;
  addr_t  addr_q;
  addr_t  first_addr;

  // Engine slice starts at base + id * count words
  assign first_addr = desc.base + addr_t'(ENGINE_ID) * addr_t'(desc.count) * WORD_STEP;

  // --------------------
  // Request sequencing
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      busy_q    <= 1'b0;
      remaining <= '0;
    end else if (!busy_q) begin
      // Zero count leaves the engine idle
      if (desc.start && (desc.count != '0)) begin
        busy_q    <= 1'b1;
        remaining <= desc.count;
      end
    end else if (req_port.grant) begin
      remaining <= remaining - count_t'(1);
      if (req_port.last) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Address walk, ascending
  always_ff @(posedge ap_clk) begin
    if (!busy_q && desc.start) begin
      addr_q <= first_addr;
    end else if (busy_q && req_port.grant) begin
      addr_q <= addr_q + WORD_STEP;
    end
  end

  // Request held until granted
  assign req_port.req     = busy_q;
  assign req_port.payload = '{addr: addr_q, engine: engine_id_t'(ENGINE_ID)};
  assign req_port.last    = (remaining == count_t'(1));

  assign desc.busy[ENGINE_ID] = busy_q;

endmodule

// File: rtl/kernel_control.sv
// Kernel run control
`timescale 1ns/1ps

module kernel_control (
  input  logic                 ap_clk,
  input  logic                 control_areset,
  input  logic                 ap_start,
  input  mrg_pkg::descriptor_t descriptor_in,
  input  logic                 fifo_reset_busy,
  input  logic                 fifo_empty,
  descriptor_if.ctrl           desc,
  output logic                 ap_idle,
  output logic                 ap_ready,
  output logic                 ap_done,
  output logic                 setup_busy
);
  import mrg_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_FINISH
  } run_state_t;

  run_state_t  state;
  logic        ap_start_q;
  descriptor_t descriptor_q;
  logic        accept;
  logic        run_complete;

  // --------------------
  // Input registers
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      ap_start_q <= 1'b0;
      setup_busy <= 1'b1;
    end else begin
      ap_start_q <= ap_start;
      // Setup follows FIFO reset-busy, one stage late
      setup_busy <= fifo_reset_busy;
    end
  end

  // Descriptor payload register
  always_ff @(posedge ap_clk) begin
    descriptor_q <= descriptor_in;
  end

  // Start only from idle with setup done
  assign accept = (state == ST_IDLE) && ap_start_q && !setup_busy;

  // Busy bits lag start by one cycle, so skip the launch cycle
  assign run_complete = !desc.start && !(|desc.busy) && fifo_empty;

  // --------------------
  // Run FSM
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      state      <= ST_IDLE;
      ap_idle    <= 1'b1;
      ap_ready   <= 1'b0;
      ap_done    <= 1'b0;
      desc.start <= 1'b0;
    end else begin
      // Pulses default low
      ap_ready   <= 1'b0;
      ap_done    <= 1'b0;
      desc.start <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state      <= ST_RUN;
            ap_ready   <= 1'b1;
            ap_idle    <= 1'b0;
            desc.start <= 1'b1;
          end
        end
        ST_RUN: begin
          if (run_complete) begin
            state   <= ST_FINISH;
            ap_done <= 1'b1;
            ap_idle <= 1'b1;
          end
        end
        // Done cycle, no new start accepted here
        ST_FINISH: state <= ST_IDLE;
        default:   state <= ST_IDLE;
      endcase
    end
  end

  // Descriptor captured on acceptance, held for the run
  always_ff @(posedge ap_clk) begin
    if (accept) begin
      desc.base  <= descriptor_q.base;
      desc.count <= descriptor_q.count;
    end
  end

endmodule

// File: rtl/mrg_if.sv
// Descriptor and request interfaces
`timescale 1ns/1ps
`include "mrg_cfg.svh"

// --------------------
// Descriptor fan-out
// --------------------
interface descriptor_if #(
  parameter int NUM_ENGINES = `MRG_NUM_ENGINES
) ();

  // One-cycle launch pulse
  logic            start;
  // Held for the whole run
  mrg_pkg::addr_t  base;
  mrg_pkg::count_t count;
  // One bit per engine, each driven by its own engine
  wire [NUM_ENGINES-1:0] busy;

  modport ctrl (output start, output base, output count, input busy);
  modport engine (input start, input base, input count, output busy);

endinterface

// --------------------
// Engine to arbiter
// --------------------
interface engine_request_if ();

  // Level, held until grant
  logic                  req;
  mrg_pkg::mem_request_t payload;
  // Single-cycle grant pulse
  logic                  grant;
  // Final request of the run
  logic                  last;

  modport engine (output req, output payload, output last, input grant);
  modport arbiter (input req, input payload, input last, output grant);

endinterface

// File: rtl/mrg_pkg.sv
// Front end shared types
package mrg_pkg;

  `include "mrg_cfg.svh"

  // Index width, never below one bit
  function automatic int idx_width(input int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

  localparam int ENGINE_ID_W = idx_width(`MRG_NUM_ENGINES);

  // --------------------
  // Scalar types
  // --------------------
  typedef logic [`MRG_ADDR_W-1:0]  addr_t;
  typedef logic [`MRG_COUNT_W-1:0] count_t;
  typedef logic [ENGINE_ID_W-1:0]  engine_id_t;

  // Read request, address plus source tag
  typedef struct packed {
    addr_t      addr;
    engine_id_t engine;
  } mem_request_t;

  // Host descriptor
  typedef struct packed {
    addr_t  base;
    count_t count;
  } descriptor_t;

endpackage

// File: rtl/mrg_cfg.svh
// Front end configuration constants
`ifndef MRG_CFG_SVH
`define MRG_CFG_SVH

// --------------------
// Engine array
// --------------------
// Number of request engines behind the arbiter
`define MRG_NUM_ENGINES 4

// Width of the per-engine request count
`define MRG_COUNT_W 8

// --------------------
// Memory side
// --------------------
`define MRG_ADDR_W 32

// Byte step between consecutive requests, one cache line
`define MRG_WORD_BYTES 64

// Request FIFO entries
`define MRG_FIFO_DEPTH 16

// Write lockout after reset, like a vendor FIFO
`define MRG_RESET_BUSY_CYCLES 4

`endif
